// ==== Bender.yml ====
package:
  name: cluster_periph

sources:
  # Design sources in compile order
  - files:
      - hdl/cluster_periph_pkg.sv
      - hdl/cluster_periph_port_fsm.sv
      - hdl/cluster_periph_regfile.sv
      - hdl/cluster_perf_counters.sv
      - hdl/cluster_periph_top.sv

  # Testbench, top module cluster_periph_tb
  - target: test
    files:
      - verif/cluster_periph_tb.sv

// ==== hdl/cluster_perf_counters.sv ====
/*
 * Bank of 48-bit performance counters.
 * Events are registered once, then each counter adds the increment picked by
 * its event and hart selection, unless software loads it in the same cycle.
 */

`timescale 1ns/1ps

module cluster_perf_counters
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  perf_cfg_t [NumPerfCounters-1:0]              perf_cfg_i,
  input  perf_load_t                                   perf_load_i,
  input  core_events_t [NrCores-1:0]                   core_events_i,
  input  icache_events_t [NrCores-1:0]                 icache_events_i,
  input  tcdm_events_t                                 tcdm_events_i,
  input  dma_events_t                                  dma_events_i,
  output logic [NumPerfCounters-1:0][CounterWidth-1:0] counters_o
);

  core_events_t [NrCores-1:0]                   core_events_q;
  icache_events_t [NrCores-1:0]                 icache_events_q;
  tcdm_events_t                                 tcdm_events_q;
  dma_events_t                                  dma_events_q;
  core_events_t [NumPerfCounters-1:0]           sel_core;
  icache_events_t [NumPerfCounters-1:0]         sel_icache;
  logic [NumPerfCounters-1:0][CounterWidth-1:0] inc;
  logic [NumPerfCounters-1:0][CounterWidth-1:0] counter_d;
  logic [NumPerfCounters-1:0][CounterWidth-1:0] counter_q;
  logic [CounterWidth-1:0]                      dma_bytes;

  // Event pipeline stage
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      core_events_q   <= '0;
      icache_events_q <= '0;
      tcdm_events_q   <= '0;
      dma_events_q    <= '0;
    end else begin
      core_events_q   <= core_events_i;
      icache_events_q <= icache_events_i;
      tcdm_events_q   <= tcdm_events_i;
      dma_events_q    <= dma_events_i;
    end
  end

  // Bytes of one AW burst, (len + 1) beats of 2**size bytes
  assign dma_bytes = (CounterWidth'(dma_events_q.aw_len) + CounterWidth'(1))
                     << dma_events_q.aw_size;

  // Hart select, out-of-range selectors leave the strobes at zero
  always_comb begin
    sel_core   = '0;
    sel_icache = '0;
    for (int i = 0; i < NumPerfCounters; i++) begin
      for (int h = 0; h < NrCores; h++) begin
        if (int'(perf_cfg_i[i].hart) == h) begin
          sel_core[i]   = core_events_q[h];
          sel_icache[i] = icache_events_q[h];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NumPerfCounters; i++) begin
      inc[i] = '0;
      case (perf_cfg_i[i].evt)
        EV_CYCLE:          inc[i] = CounterWidth'(1);
        EV_TCDM_ACCESSED:  inc[i] = CounterWidth'(tcdm_events_q.inc_accessed);
        EV_TCDM_CONGESTED: inc[i] = CounterWidth'(tcdm_events_q.inc_congested);
        EV_RETIRED_INSTR:  inc[i] = CounterWidth'(sel_core[i].retired_instr);
        EV_RETIRED_LOAD:   inc[i] = CounterWidth'(sel_core[i].retired_load);
        EV_ISSUE_FPU:      inc[i] = CounterWidth'(sel_core[i].issue_fpu);
        EV_DMA_BUSY:       inc[i] = CounterWidth'(dma_events_q.busy);
        EV_DMA_AW_DONE:    inc[i] = CounterWidth'(dma_events_q.aw_done);
        EV_DMA_AW_BW: begin
          if (dma_events_q.aw_done) begin
            inc[i] = dma_bytes;
          end
        end
        EV_ICACHE_MISS:    inc[i] = CounterWidth'(sel_icache[i].l0_miss);
        EV_ICACHE_HIT:     inc[i] = CounterWidth'(sel_icache[i].l0_hit);
        default:           inc[i] = '0;
      endcase
    end
  end

  // Software load wins over the increment
  always_comb begin
    for (int i = 0; i < NumPerfCounters; i++) begin
      counter_d[i] = counter_q[i] + inc[i];
      if (perf_load_i.valid && perf_load_i.idx == PerfIdxWidth'(i)) begin
        counter_d[i] = CounterWidth'(perf_load_i.value);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      counter_q <= '0;
    end else begin
      counter_q <= counter_d;
    end
  end

  assign counters_o = counter_q;

endmodule

// ==== hdl/cluster_periph_pkg.sv ====
/*
 * Shared types and constants for the cluster peripheral block.
 * Holds the register map, the event encoding and the bus and event structs.
 */

package cluster_periph_pkg;

  // Register port widths
  localparam int unsigned AddrWidth    = 8;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned CounterWidth = 48;
  localparam int unsigned HartIdWidth  = 10;
  // Counter index in a load request, up to 16 counters
  localparam int unsigned PerfIdxWidth = 4;

  // Register map, byte offsets
  localparam logic [AddrWidth-1:0] PerfCfgBase   = 8'h00;
  localparam logic [AddrWidth-1:0] PerfCntBase   = 8'h40;
  localparam logic [AddrWidth-1:0] ClintSetOff   = 8'h80;
  localparam logic [AddrWidth-1:0] ClintClearOff = 8'h84;
  localparam logic [AddrWidth-1:0] PrefetchOff   = 8'h88;
  localparam logic [AddrWidth-1:0] HartBaseOff   = 8'h8C;
  localparam logic [AddrWidth-1:0] BarrierOff    = 8'h90;

  // Countable events, unlisted codes count nothing
  typedef enum logic [4:0] {
    EV_NONE           = 5'd0,
    EV_CYCLE          = 5'd1,
    EV_TCDM_ACCESSED  = 5'd2,
    EV_TCDM_CONGESTED = 5'd3,
    EV_RETIRED_INSTR  = 5'd4,
    EV_RETIRED_LOAD   = 5'd5,
    EV_ISSUE_FPU      = 5'd6,
    EV_DMA_BUSY       = 5'd7,
    EV_DMA_AW_DONE    = 5'd8,
    EV_DMA_AW_BW      = 5'd9,
    EV_ICACHE_MISS    = 5'd10,
    EV_ICACHE_HIT     = 5'd11
  } perf_event_e;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACK,
    WAIT_LOW
  } port_state_e;

  // Per-hart strobes
  typedef struct packed {
    logic retired_instr;
    logic retired_load;
    logic issue_fpu;
  } core_events_t;

  typedef struct packed {
    logic l0_miss;
    logic l0_hit;
  } icache_events_t;

  // Cluster-wide strobes
  typedef struct packed {
    logic inc_accessed;
    logic inc_congested;
  } tcdm_events_t;

  typedef struct packed {
    logic       busy;
    logic       aw_done;
    logic [7:0] aw_len;
    logic [2:0] aw_size;
  } dma_events_t;

  // Selection of one counter, event in cfg bits 4:0 and hart in bits 15:8
  typedef struct packed {
    perf_event_e evt;
    logic [7:0]  hart;
  } perf_cfg_t;

  typedef struct packed {
    logic                    valid;
    logic [PerfIdxWidth-1:0] idx;
    logic [DataWidth-1:0]    value;
  } perf_load_t;

  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                 ack;
    logic                 error;
    logic [DataWidth-1:0] rdata;
  } reg_rsp_t;

endpackage

// ==== hdl/cluster_periph_port_fsm.sv ====
/*
 * Four-phase req/ack slave for the peripheral register port.
 * Issues one access strobe per request and holds the response until req drops.
 */

`timescale 1ns/1ps

module cluster_periph_port_fsm
  import cluster_periph_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  reg_req_t             req_i,
  output reg_rsp_t             rsp_o,
  output logic                 access_o,
  input  logic [DataWidth-1:0] rdata_i,
  input  logic                 error_i
);

  port_state_e          state_q;
  port_state_e          state_d;
  logic [DataWidth-1:0] rdata_q;
  logic                 error_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i.req) begin
          state_d = ACCESS;
        end
      end
      // Single cycle, the register file acts here
      ACCESS: begin
        state_d = ACK;
      end
      ACK: begin
        state_d = req_i.req ? WAIT_LOW : IDLE;
      end
      // Master still holds req, keep ack up
      WAIT_LOW: begin
        if (!req_i.req) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the response at the end of the access cycle
  always_ff @(posedge clk_i) begin
    if (state_q == ACCESS) begin
      rdata_q <= rdata_i;
      error_q <= error_i;
    end
  end

  assign access_o    = (state_q == ACCESS);
  assign rsp_o.ack   = (state_q == ACK) || (state_q == WAIT_LOW);
  assign rsp_o.error = error_q;
  assign rsp_o.rdata = rdata_q;

endmodule

// ==== hdl/cluster_periph_regfile.sv ====
/*
 * Register file of the cluster peripheral block.
 * Decodes the port address, holds wake-up mask, prefetch enable and
 * counter selections, and turns low-word counter writes into load requests.
 */

`timescale 1ns/1ps

module cluster_periph_regfile
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         access_i,
  input  reg_req_t                                     req_i,
  output logic [DataWidth-1:0]                         rdata_o,
  output logic                                         error_o,
  input  logic [HartIdWidth-1:0]                       hart_base_id_i,
  input  logic [NumPerfCounters-1:0][CounterWidth-1:0] counters_i,
  output perf_cfg_t [NumPerfCounters-1:0]              perf_cfg_o,
  output perf_load_t                                   perf_load_o,
  output logic [NrCores-1:0]                           cl_clint_o,
  output logic                                         icache_prefetch_enable_o
);

  localparam int unsigned CntHiWidth = CounterWidth - DataWidth;

  logic [NumPerfCounters-1:0]      cfg_hit;
  logic [NumPerfCounters-1:0]      cnt_lo_hit;
  logic                            clint_set_hit;
  logic                            clint_clr_hit;
  logic                            prefetch_hit;
  logic                            wr_en;
  logic [DataWidth-1:0]            clint_q;
  logic                            prefetch_q;
  perf_cfg_t [NumPerfCounters-1:0] cfg_q;

  assign wr_en = access_i & req_i.we;

  // Address decode and read mux
  always_comb begin
    cfg_hit       = '0;
    cnt_lo_hit    = '0;
    clint_set_hit = 1'b0;
    clint_clr_hit = 1'b0;
    prefetch_hit  = 1'b0;
    rdata_o       = '0;
    error_o       = 1'b0;
    if (req_i.addr == ClintSetOff || req_i.addr == ClintClearOff) begin
      clint_set_hit = (req_i.addr == ClintSetOff);
      clint_clr_hit = (req_i.addr == ClintClearOff);
      rdata_o       = clint_q;
    end else if (req_i.addr == PrefetchOff) begin
      prefetch_hit = 1'b1;
      rdata_o      = {{(DataWidth-1){1'b0}}, prefetch_q};
    end else if (req_i.addr == HartBaseOff) begin
      rdata_o = {{(DataWidth-HartIdWidth){1'b0}}, hart_base_id_i};
    end else if (req_i.addr == BarrierOff) begin
      // Barrier lives outside the cluster and reads as zero here
      rdata_o = '0;
    end else begin
      error_o = 1'b1;
      for (int k = 0; k < NumPerfCounters; k++) begin
        if (req_i.addr == AddrWidth'(PerfCfgBase + 4 * k)) begin
          cfg_hit[k] = 1'b1;
          error_o    = 1'b0;
          rdata_o    = {16'b0, cfg_q[k].hart, 3'b0, cfg_q[k].evt};
        end
        if (req_i.addr == AddrWidth'(PerfCntBase + 8 * k)) begin
          cnt_lo_hit[k] = 1'b1;
          error_o       = 1'b0;
          rdata_o       = counters_i[k][DataWidth-1:0];
        end
        // High half is read-only, writes fall through silently
        if (req_i.addr == AddrWidth'(PerfCntBase + 8 * k + 4)) begin
          error_o = 1'b0;
          rdata_o = {{(DataWidth-CntHiWidth){1'b0}}, counters_i[k][CounterWidth-1:DataWidth]};
        end
      end
    end
  end

  // One-cycle load request toward the counter bank
  always_comb begin
    perf_load_o = '0;
    for (int k = 0; k < NumPerfCounters; k++) begin
      if (wr_en && cnt_lo_hit[k]) begin
        perf_load_o.valid = 1'b1;
        perf_load_o.idx   = PerfIdxWidth'(k);
        perf_load_o.value = req_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      clint_q    <= '0;
      prefetch_q <= 1'b0;
      cfg_q      <= '0;
    end else if (wr_en) begin
      if (clint_set_hit) begin
        clint_q <= clint_q | req_i.wdata;
      end
      if (clint_clr_hit) begin
        clint_q <= clint_q & ~req_i.wdata;
      end
      if (prefetch_hit) begin
        prefetch_q <= req_i.wdata[0];
      end
      for (int k = 0; k < NumPerfCounters; k++) begin
        if (cfg_hit[k]) begin
          cfg_q[k].evt  <= perf_event_e'(req_i.wdata[4:0]);
          cfg_q[k].hart <= req_i.wdata[15:8];
        end
      end
    end
  end

  // Upper mask bits are stored but drive no core
  assign cl_clint_o               = clint_q[NrCores-1:0];
  assign icache_prefetch_enable_o = prefetch_q;
  assign perf_cfg_o               = cfg_q;

endmodule

// ==== hdl/cluster_periph_top.sv ====
/*
 * Cluster peripheral block, reached through a four-phase req/ack register port.
 * Connects the port FSM, the register file and the performance counter bank.
 */

`timescale 1ns/1ps

module cluster_periph_top
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  reg_req_t                     reg_req_i,
  output reg_rsp_t                     reg_rsp_o,
  input  logic [HartIdWidth-1:0]       cluster_hart_base_id_i,
  input  core_events_t [NrCores-1:0]   core_events_i,
  input  icache_events_t [NrCores-1:0] icache_events_i,
  input  tcdm_events_t                 tcdm_events_i,
  input  dma_events_t                  dma_events_i,
  output logic [NrCores-1:0]           cl_clint_o,
  output logic                         icache_prefetch_enable_o
);

  logic                                         access;
  logic [DataWidth-1:0]                         rdata;
  logic                                         error;
  perf_cfg_t [NumPerfCounters-1:0]              perf_cfg;
  perf_load_t                                   perf_load;
  logic [NumPerfCounters-1:0][CounterWidth-1:0] counters;

  cluster_periph_port_fsm i_port_fsm (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (reg_req_i),
    .rsp_o    (reg_rsp_o),
    .access_o (access),
    .rdata_i  (rdata),
    .error_i  (error)
  );

  cluster_periph_regfile #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) i_regfile (
    .clk_i                    (clk_i),
    .rst_n_i                  (rst_n_i),
    .access_i                 (access),
    .req_i                    (reg_req_i),
    .rdata_o                  (rdata),
    .error_o                  (error),
    .hart_base_id_i           (cluster_hart_base_id_i),
    .counters_i               (counters),
    .perf_cfg_o               (perf_cfg),
    .perf_load_o              (perf_load),
    .cl_clint_o               (cl_clint_o),
    .icache_prefetch_enable_o (icache_prefetch_enable_o)
  );

  cluster_perf_counters #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) i_perf_counters (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .perf_cfg_i      (perf_cfg),
    .perf_load_i     (perf_load),
    .core_events_i   (core_events_i),
    .icache_events_i (icache_events_i),
    .tcdm_events_i   (tcdm_events_i),
    .dma_events_i    (dma_events_i),
    .counters_o      (counters)
  );

endmodule

// ==== verif/cluster_periph_tb.sv ====
/*
 * Self-checking testbench for the cluster peripheral block.
 * Drives the four-phase register port and the event strobes, and compares
 * read data against a reference model of the registers and counters.
 */

`timescale 1ns/1ps

module cluster_periph_tb
  import cluster_periph_pkg::*;
;

  localparam int unsigned NrCores         = 4;
  localparam int unsigned NumPerfCounters = 4;
  localparam int          ClkPeriod       = 10;
  localparam int          AckTimeout      = 16;
  localparam int          AccessBound     = 2 * AckTimeout + 2;
  localparam int          NumAccesses     = 96;
  localparam int          BurstLen        = 32;
  localparam int          NumBursts       = 6;
  localparam int          WatchdogCycles  =
    NumAccesses * AccessBound + NumBursts * (BurstLen + 2) + 16;
  localparam logic [HartIdWidth-1:0] HartBaseId = 10'h2A5;

  logic                         clk;
  logic                         rst_n;
  reg_req_t                     reg_req;
  reg_rsp_t                     reg_rsp;
  core_events_t [NrCores-1:0]   core_ev;
  icache_events_t [NrCores-1:0] ic_ev;
  tcdm_events_t                 tcdm_ev;
  dma_events_t                  dma_ev;
  logic [NrCores-1:0]           cl_clint;
  logic                         prefetch_en;

  // Reference model state
  logic [DataWidth-1:0]    model_mask;
  logic                    model_pf;
  perf_cfg_t               model_cfg [NumPerfCounters];
  logic [CounterWidth-1:0] model_cnt [NumPerfCounters];
  logic [31:0]             rng_state = 32'h9f50;

  cluster_periph_top #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) DUT (
    .clk_i                    (clk),
    .rst_n_i                  (rst_n),
    .reg_req_i                (reg_req),
    .reg_rsp_o                (reg_rsp),
    .cluster_hart_base_id_i   (HartBaseId),
    .core_events_i            (core_ev),
    .icache_events_i          (ic_ev),
    .tcdm_events_i            (tcdm_ev),
    .dma_events_i             (dma_ev),
    .cl_clint_o               (cl_clint),
    .icache_prefetch_enable_o (prefetch_en)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired before the test sequence finished");
    $display("Done: errors found");
    $fatal(1, "Simulation stopped by watchdog");
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("Done: errors found");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Increment of one counter for one event sample
  function automatic logic [CounterWidth-1:0] event_inc(
    input perf_cfg_t                    cfg,
    input core_events_t [NrCores-1:0]   core,
    input icache_events_t [NrCores-1:0] ic,
    input tcdm_events_t                 tcdm,
    input dma_events_t                  dma
  );
    core_events_t   c;
    icache_events_t i;
    c = '0;
    i = '0;
    if (cfg.hart < NrCores) begin
      c = core[cfg.hart];
      i = ic[cfg.hart];
    end
    case (cfg.evt)
      EV_CYCLE:          return 48'd1;
      EV_TCDM_ACCESSED:  return 48'(tcdm.inc_accessed);
      EV_TCDM_CONGESTED: return 48'(tcdm.inc_congested);
      EV_RETIRED_INSTR:  return 48'(c.retired_instr);
      EV_RETIRED_LOAD:   return 48'(c.retired_load);
      EV_ISSUE_FPU:      return 48'(c.issue_fpu);
      EV_DMA_BUSY:       return 48'(dma.busy);
      EV_DMA_AW_DONE:    return 48'(dma.aw_done);
      EV_DMA_AW_BW:      return dma.aw_done ? ((48'(dma.aw_len) + 48'd1) << dma.aw_size) : 48'd0;
      EV_ICACHE_MISS:    return 48'(i.l0_miss);
      EV_ICACHE_HIT:     return 48'(i.l0_hit);
      default:           return 48'd0;
    endcase
  endfunction

  // Expected {error, rdata} of a read at addr
  function automatic logic [32:0] expected_read(input logic [AddrWidth-1:0] addr);
    if (addr == ClintSetOff || addr == ClintClearOff) return {1'b0, model_mask};
    if (addr == PrefetchOff) return {1'b0, 31'b0, model_pf};
    if (addr == HartBaseOff) return {1'b0, 22'b0, HartBaseId};
    if (addr == BarrierOff) return 33'b0;
    for (int k = 0; k < NumPerfCounters; k++) begin
      if (addr == 8'(PerfCfgBase + 4 * k)) begin
        return {1'b0, 16'b0, model_cfg[k].hart, 3'b0, model_cfg[k].evt};
      end
      if (addr == 8'(PerfCntBase + 8 * k)) return {1'b0, model_cnt[k][31:0]};
      if (addr == 8'(PerfCntBase + 8 * k + 4)) return {1'b0, 16'b0, model_cnt[k][47:32]};
    end
    return {1'b1, 32'b0};
  endfunction

  function automatic void model_write(input logic [AddrWidth-1:0] addr,
                                      input logic [DataWidth-1:0] data);
    if (addr == ClintSetOff) model_mask = model_mask | data;
    if (addr == ClintClearOff) model_mask = model_mask & ~data;
    if (addr == PrefetchOff) model_pf = data[0];
    for (int k = 0; k < NumPerfCounters; k++) begin
      if (addr == 8'(PerfCfgBase + 4 * k)) begin
        model_cfg[k].evt  = perf_event_e'(data[4:0]);
        model_cfg[k].hart = data[15:8];
      end
      // High word writes are dropped
      if (addr == 8'(PerfCntBase + 8 * k)) model_cnt[k] = 48'(data);
    end
  endfunction

  // Full four-phase transfer bounded on both ack edges
  task automatic handshake(input logic we, input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata,
                           output logic [DataWidth-1:0] rdata, output logic err);
    int waited;
    @(posedge clk);
    #1;
    reg_req.we    = we;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req.req   = 1'b1;
    waited = 0;
    while (!reg_rsp.ack && waited < AckTimeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!reg_rsp.ack) begin
      $display("Timed out waiting for ack at address 0x%02h", addr);
      $display("Done: errors found");
      $fatal(1, "No response on the register port");
    end
    rdata   = reg_rsp.rdata;
    err     = reg_rsp.error;
    reg_req = '0;
    waited  = 0;
    while (reg_rsp.ack && waited < AckTimeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (reg_rsp.ack) begin
      $display("Ack stayed high after req was dropped at address 0x%02h", addr);
      $display("Done: errors found");
      $fatal(1, "Handshake did not complete");
    end
  endtask

  task automatic bus_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
    logic [32:0]          exp;
    logic [DataWidth-1:0] rdata;
    logic                 err;
    exp = expected_read(addr);
    handshake(1'b1, addr, data, rdata, err);
    model_write(addr, data);
    check_value($sformatf("write error@0x%02h", addr), err, exp[32]);
  endtask

  task automatic bus_read(input logic [AddrWidth-1:0] addr,
                          output logic [DataWidth-1:0] rdata, output logic err);
    handshake(1'b0, addr, '0, rdata, err);
  endtask

  task automatic read_check(input logic [AddrWidth-1:0] addr);
    logic [32:0]          exp;
    logic [DataWidth-1:0] rdata;
    logic                 err;
    exp = expected_read(addr);
    bus_read(addr, rdata, err);
    check_value($sformatf("rdata@0x%02h", addr), rdata, exp[31:0]);
    check_value($sformatf("error@0x%02h", addr), err, exp[32]);
  endtask

  // Random strobes for len cycles and then all events back to zero
  task automatic drive_burst(input int len, input logic force_done);
    logic [31:0] r0;
    logic [31:0] r1;
    repeat (len) begin
      @(posedge clk);
      #1;
      r0      = xorshift32();
      r1      = xorshift32();
      core_ev = r0[11:0];
      ic_ev   = r0[19:12];
      tcdm_ev = r0[21:20];
      dma_ev  = r1[12:0];
      if (force_done) dma_ev.aw_done = 1'b1;
      for (int k = 0; k < NumPerfCounters; k++) begin
        model_cnt[k] = model_cnt[k] + event_inc(model_cfg[k], core_ev, ic_ev, tcdm_ev, dma_ev);
      end
    end
    @(posedge clk);
    #1;
    core_ev = '0;
    ic_ev   = '0;
    tcdm_ev = '0;
    dma_ev  = '0;
  endtask

  function automatic logic [AddrWidth-1:0] cfg_addr(input int k);
    return 8'(PerfCfgBase + 4 * k);
  endfunction

  function automatic logic [AddrWidth-1:0] cnt_addr(input int k);
    return 8'(PerfCntBase + 8 * k);
  endfunction

  initial begin
    logic [31:0]          r;
    logic [DataWidth-1:0] first;
    logic [DataWidth-1:0] second;
    logic                 err;
    logic [47:0]          snap0;
    logic [47:0]          snap1;
    rst_n   = 1'b0;
    reg_req = '0;
    core_ev = '0;
    ic_ev   = '0;
    tcdm_ev = '0;
    dma_ev  = '0;
    model_mask = '0;
    model_pf   = 1'b0;
    for (int k = 0; k < NumPerfCounters; k++) begin
      model_cfg[k] = '0;
      model_cnt[k] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset values
    check_value("cl_clint_o", cl_clint, '0);
    check_value("icache_prefetch_enable_o", prefetch_en, 1'b0);
    for (int k = 0; k < NumPerfCounters; k++) begin
      read_check(cfg_addr(k));
      read_check(cnt_addr(k));
      read_check(cnt_addr(k) + 8'd4);
    end
    read_check(HartBaseOff);
    read_check(BarrierOff);
    read_check(8'h3C);
    read_check(8'hF4);

    // Wake-up mask set and clear and prefetch enable
    for (int i = 0; i < 12; i++) begin
      r = xorshift32();
      bus_write(r[0] ? ClintSetOff : ClintClearOff, xorshift32());
      check_value("cl_clint_o", cl_clint, model_mask[NrCores-1:0]);
      read_check(ClintSetOff);
    end
    read_check(ClintClearOff);
    bus_write(PrefetchOff, 32'h1);
    check_value("icache_prefetch_enable_o", prefetch_en, model_pf);
    read_check(PrefetchOff);
    bus_write(PrefetchOff, 32'h0);
    check_value("icache_prefetch_enable_o", prefetch_en, model_pf);

    // Random event and in-range hart per counter with EV_CYCLE kept for last
    for (int k = 0; k < NumPerfCounters; k++) begin
      r = xorshift32();
      bus_write(cfg_addr(k), {16'b0, 8'(r[15:8] % NrCores), 3'b0, 5'(2 + r[7:0] % 10)});
      drive_burst(BurstLen, 1'b0);
      read_check(cnt_addr(k));
      read_check(cnt_addr(k) + 8'd4);
    end

    // Out-of-range hart and EV_NONE hold their counters
    r = xorshift32();
    bus_write(cfg_addr(0), {16'b0, 8'(NrCores + r[3:0]), 3'b0, 5'(EV_RETIRED_INSTR)});
    bus_write(cfg_addr(1), {16'b0, 8'd1, 3'b0, 5'(EV_NONE)});
    snap0 = model_cnt[0];
    snap1 = model_cnt[1];
    drive_burst(BurstLen, 1'b0);
    bus_read(cnt_addr(0), first, err);
    check_value("counter0 low", first, snap0[31:0]);
    bus_read(cnt_addr(1), first, err);
    check_value("counter1 low", first, snap1[31:0]);
    read_check(cnt_addr(0) + 8'd4);
    read_check(cnt_addr(1) + 8'd4);

    // DMA bandwidth after a load close to the 32-bit boundary
    // Each forced AW adds at least one byte so the burst carries into the high word
    bus_write(cfg_addr(2), {27'b0, 5'(EV_DMA_AW_BW)});
    bus_write(cnt_addr(2), 32'hFFFF_FFE0);
    read_check(cnt_addr(2));
    drive_burst(BurstLen, 1'b1);
    read_check(cnt_addr(2));
    read_check(cnt_addr(2) + 8'd4);
    bus_write(cnt_addr(2) + 8'd4, xorshift32());
    read_check(cnt_addr(2) + 8'd4);
    bus_write(cnt_addr(2), 32'h1234_5678);
    read_check(cnt_addr(2));
    read_check(cnt_addr(2) + 8'd4);

    // Free-running cycle count
    bus_write(cfg_addr(3), {27'b0, 5'(EV_CYCLE)});
    bus_read(cnt_addr(3), first, err);
    bus_read(cnt_addr(3), second, err);
    check_value("cycle count increase", (second > first) && (second - first >= 3), 1'b1);

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/cluster_periph_pkg.sv
hdl/cluster_periph_port_fsm.sv
hdl/cluster_periph_regfile.sv
hdl/cluster_perf_counters.sv
hdl/cluster_periph_top.sv
verif/cluster_periph_tb.sv
